//--- design/mips_decode_pkg.sv
package mips_decode_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  alu_class_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [2:0]  branch_cond_t;

	// field positions
	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int FUNCT_MSB = 5;
	localparam int FUNCT_LSB = 0;

	// primary opcodes
	localparam opcode_t OP_RTYPE  = 6'b000000;
	localparam opcode_t OP_REGIMM = 6'b000001;
	localparam opcode_t OP_J      = 6'b000010;
	localparam opcode_t OP_JAL    = 6'b000011;
	localparam opcode_t OP_BEQ    = 6'b000100;
	localparam opcode_t OP_BNE    = 6'b000101;
	localparam opcode_t OP_BLEZ   = 6'b000110;
	localparam opcode_t OP_BGTZ   = 6'b000111;
	localparam opcode_t OP_ADDI   = 6'b001000;
	localparam opcode_t OP_ADDIU  = 6'b001001;
	localparam opcode_t OP_SLTI   = 6'b001010;
	localparam opcode_t OP_SLTIU  = 6'b001011;
	localparam opcode_t OP_ANDI   = 6'b001100;
	localparam opcode_t OP_ORI    = 6'b001101;
	localparam opcode_t OP_XORI   = 6'b001110;
	localparam opcode_t OP_LUI    = 6'b001111;
	localparam opcode_t OP_COP0   = 6'b010000;
	localparam opcode_t OP_LB     = 6'b100000;
	localparam opcode_t OP_LH     = 6'b100001;
	localparam opcode_t OP_LW     = 6'b100011;
	localparam opcode_t OP_LBU    = 6'b100100;
	localparam opcode_t OP_LHU    = 6'b100101;
	localparam opcode_t OP_SB     = 6'b101000;
	localparam opcode_t OP_SH     = 6'b101001;
	localparam opcode_t OP_SW     = 6'b101011;

	// R-type function field
	localparam funct_t FN_SLL     = 6'b000000;
	localparam funct_t FN_SRL     = 6'b000010;
	localparam funct_t FN_SRA     = 6'b000011;
	localparam funct_t FN_SLLV    = 6'b000100;
	localparam funct_t FN_SRLV    = 6'b000110;
	localparam funct_t FN_SRAV    = 6'b000111;
	localparam funct_t FN_JR      = 6'b001000;
	localparam funct_t FN_JALR    = 6'b001001;
	localparam funct_t FN_SYSCALL = 6'b001100;
	localparam funct_t FN_BREAK   = 6'b001101;
	localparam funct_t FN_MFHI    = 6'b010000;
	localparam funct_t FN_MTHI    = 6'b010001;
	localparam funct_t FN_MFLO    = 6'b010010;
	localparam funct_t FN_MTLO    = 6'b010011;
	localparam funct_t FN_MULT    = 6'b011000;
	localparam funct_t FN_MULTU   = 6'b011001;
	localparam funct_t FN_DIV     = 6'b011010;
	localparam funct_t FN_DIVU    = 6'b011011;
	localparam funct_t FN_ADD     = 6'b100000;
	localparam funct_t FN_ADDU    = 6'b100001;
	localparam funct_t FN_SUB     = 6'b100010;
	localparam funct_t FN_SUBU    = 6'b100011;
	localparam funct_t FN_AND     = 6'b100100;
	localparam funct_t FN_OR      = 6'b100101;
	localparam funct_t FN_XOR     = 6'b100110;
	localparam funct_t FN_NOR     = 6'b100111;
	localparam funct_t FN_SLT     = 6'b101010;
	localparam funct_t FN_SLTU    = 6'b101011;

	// REGIMM selectors in rt
	localparam reg_idx_t RT_BLTZ   = 5'b00000;
	localparam reg_idx_t RT_BGEZ   = 5'b00001;
	localparam reg_idx_t RT_BLTZAL = 5'b10000;
	localparam reg_idx_t RT_BGEZAL = 5'b10001;

	// COP0 selectors in rs, ERET is the whole low 26 bits
	localparam reg_idx_t    RS_MFC0   = 5'b00000;
	localparam reg_idx_t    RS_MTC0   = 5'b00100;
	localparam logic [25:0] ERET_WORD = 26'h2000018;

	localparam alu_class_t CLS_NONE  = 4'd0;
	localparam alu_class_t CLS_RTYPE = 4'd1;
	localparam alu_class_t CLS_ADDI  = 4'd2;
	localparam alu_class_t CLS_ADDIU = 4'd3;
	localparam alu_class_t CLS_SLTI  = 4'd4;
	localparam alu_class_t CLS_SLTIU = 4'd5;
	localparam alu_class_t CLS_ANDI  = 4'd6;
	localparam alu_class_t CLS_ORI   = 4'd7;
	localparam alu_class_t CLS_XORI  = 4'd8;
	localparam alu_class_t CLS_LUI   = 4'd9;
	localparam alu_class_t CLS_MEM   = 4'd10;
	localparam alu_class_t CLS_MTC0  = 4'd11;
	localparam alu_class_t CLS_MFC0  = 4'd12;

	localparam alu_op_t ALU_NOP  = 4'd0;
	localparam alu_op_t ALU_ADD  = 4'd1;
	localparam alu_op_t ALU_ADDU = 4'd2;
	localparam alu_op_t ALU_SUB  = 4'd3;
	localparam alu_op_t ALU_SUBU = 4'd4;
	localparam alu_op_t ALU_AND  = 4'd5;
	localparam alu_op_t ALU_OR   = 4'd6;
	localparam alu_op_t ALU_XOR  = 4'd7;
	localparam alu_op_t ALU_NOR  = 4'd8;
	localparam alu_op_t ALU_SLT  = 4'd9;
	localparam alu_op_t ALU_SLTU = 4'd10;
	localparam alu_op_t ALU_SLL  = 4'd11;
	localparam alu_op_t ALU_SRL  = 4'd12;
	localparam alu_op_t ALU_SRA  = 4'd13;
	localparam alu_op_t ALU_LUI  = 4'd14;

	localparam branch_cond_t BR_NONE = 3'd0;
	localparam branch_cond_t BR_EQ   = 3'd1;
	localparam branch_cond_t BR_NE   = 3'd2;
	localparam branch_cond_t BR_LEZ  = 3'd3;
	localparam branch_cond_t BR_GTZ  = 3'd4;
	localparam branch_cond_t BR_LTZ  = 3'd5;
	localparam branch_cond_t BR_GEZ  = 3'd6;

endpackage

//--- design/main_decoder.sv
`timescale 1ns/1ps

module main_decoder import mips_decode_pkg::*; (
	input  instr_t     instr,
	output logic       reg_write,
	output logic       reg_dst,
	output logic       is_imm,
	output logic       sign_ext,
	output logic       mem_to_reg,
	output logic       mem_read,
	output logic       mem_write,
	output logic       is_mfc,
	output alu_class_t alu_class,
	output logic       reserved_instr,
	output logic       single_issue
);

	opcode_t  op;
	funct_t   funct;
	reg_idx_t rs;
	reg_idx_t rt;

	assign op    = instr[OP_MSB:OP_LSB];
	assign funct = instr[FUNCT_MSB:FUNCT_LSB];
	assign rs    = instr[RS_MSB:RS_LSB];
	assign rt    = instr[RT_MSB:RT_LSB];

	// logical immediates and lui take a zero-extended immediate
	assign sign_ext = !(op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});

	always_comb begin
		reg_write      = 1'b0;
		reg_dst        = 1'b0;
		is_imm         = 1'b0;
		mem_to_reg     = 1'b0;
		mem_read       = 1'b0;
		mem_write      = 1'b0;
		is_mfc         = 1'b0;
		alu_class      = CLS_NONE;
		reserved_instr = 1'b0;
		single_issue   = 1'b0;
		case (op)
			OP_RTYPE: begin
				case (funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
					FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
					FN_MFHI, FN_MFLO: begin
						reg_write = 1'b1;
						alu_class = CLS_RTYPE;
					end
					FN_JALR: begin
						reg_write = 1'b1;
						reg_dst   = 1'b1;
						alu_class = CLS_RTYPE;
					end
					// no register result
					FN_JR, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
					FN_MTHI, FN_MTLO, FN_SYSCALL, FN_BREAK: begin
						alu_class = CLS_RTYPE;
					end
					default: reserved_instr = 1'b1;
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				reg_write = 1'b1;
				is_imm    = 1'b1;
				// immediate classes follow the opcode order
				alu_class = CLS_ADDI + alu_class_t'(op[2:0]);
			end
			OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
				reg_write    = 1'b1;
				is_imm       = 1'b1;
				mem_to_reg   = 1'b1;
				mem_read     = 1'b1;
				alu_class    = CLS_MEM;
				single_issue = 1'b1;
			end
			OP_SW, OP_SB, OP_SH: begin
				is_imm       = 1'b1;
				mem_write    = 1'b1;
				alu_class    = CLS_MEM;
				single_issue = 1'b1;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J: begin
			end
			OP_JAL: begin
				reg_write = 1'b1;
				reg_dst   = 1'b1;
			end
			OP_REGIMM: begin
				case (rt)
					// link to r31
					RT_BLTZAL, RT_BGEZAL: begin
						reg_write = 1'b1;
						reg_dst   = 1'b1;
					end
					RT_BLTZ, RT_BGEZ: begin
					end
					default: reserved_instr = 1'b1;
				endcase
			end
			OP_COP0: begin
				single_issue = 1'b1;
				case (rs)
					RS_MTC0: alu_class = CLS_MTC0;
					RS_MFC0: begin
						reg_write = 1'b1;
						is_imm    = 1'b1;
						is_mfc    = 1'b1;
						alu_class = CLS_MFC0;
					end
					default: reserved_instr = (instr[RS_MSB:FUNCT_LSB] != ERET_WORD);
				endcase
			end
			default: reserved_instr = 1'b1;
		endcase
	end

endmodule

//--- design/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder import mips_decode_pkg::*; (
	input  alu_class_t alu_class,
	input  instr_t     instr,
	output alu_op_t    alu_op
);

	funct_t  funct;
	alu_op_t rtype_op;

	assign funct = instr[FUNCT_MSB:FUNCT_LSB];

	// variable shifts reuse the fixed shift ops
	always_comb begin
		case (funct)
			FN_ADD:          rtype_op = ALU_ADD;
			FN_ADDU:         rtype_op = ALU_ADDU;
			FN_SUB:          rtype_op = ALU_SUB;
			FN_SUBU:         rtype_op = ALU_SUBU;
			FN_AND:          rtype_op = ALU_AND;
			FN_OR:           rtype_op = ALU_OR;
			FN_XOR:          rtype_op = ALU_XOR;
			FN_NOR:          rtype_op = ALU_NOR;
			FN_SLT:          rtype_op = ALU_SLT;
			FN_SLTU:         rtype_op = ALU_SLTU;
			FN_SLL, FN_SLLV: rtype_op = ALU_SLL;
			FN_SRL, FN_SRLV: rtype_op = ALU_SRL;
			FN_SRA, FN_SRAV: rtype_op = ALU_SRA;
			default:         rtype_op = ALU_NOP;
		endcase
	end

	always_comb begin
		case (alu_class)
			CLS_RTYPE: alu_op = rtype_op;
			CLS_ADDI:  alu_op = ALU_ADD;
			CLS_ADDIU: alu_op = ALU_ADDU;
			CLS_SLTI:  alu_op = ALU_SLT;
			CLS_SLTIU: alu_op = ALU_SLTU;
			CLS_ANDI:  alu_op = ALU_AND;
			CLS_ORI:   alu_op = ALU_OR;
			CLS_XORI:  alu_op = ALU_XOR;
			CLS_LUI:   alu_op = ALU_LUI;
			// address = base + offset
			CLS_MEM:   alu_op = ALU_ADDU;
			default:   alu_op = ALU_NOP;
		endcase
	end

endmodule

//--- design/branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder import mips_decode_pkg::*; (
	input  instr_t       instr,
	output branch_cond_t branch_cond
);

	opcode_t  op;
	reg_idx_t rt;

	assign op = instr[OP_MSB:OP_LSB];
	assign rt = instr[RT_MSB:RT_LSB];

	always_comb begin
		case (op)
			OP_BEQ:  branch_cond = BR_EQ;
			OP_BNE:  branch_cond = BR_NE;
			OP_BLEZ: branch_cond = BR_LEZ;
			OP_BGTZ: branch_cond = BR_GTZ;
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ, RT_BLTZAL: branch_cond = BR_LTZ;
					RT_BGEZ, RT_BGEZAL: branch_cond = BR_GEZ;
					// unknown selector is not a branch
					default:            branch_cond = BR_NONE;
				endcase
			end
			default: branch_cond = BR_NONE;
		endcase
	end

endmodule

//--- design/operand_decoder.sv
`timescale 1ns/1ps

module operand_decoder import mips_decode_pkg::*; (
	input  instr_t instr,
	output logic   read_rs,
	output logic   read_rt
);

	opcode_t  op;
	funct_t   funct;
	reg_idx_t rs;
	reg_idx_t rt;

	assign op    = instr[OP_MSB:OP_LSB];
	assign funct = instr[FUNCT_MSB:FUNCT_LSB];
	assign rs    = instr[RS_MSB:RS_LSB];
	assign rt    = instr[RT_MSB:RT_LSB];

	always_comb begin
		read_rs = 1'b0;
		read_rt = 1'b0;
		case (op)
			OP_RTYPE: begin
				case (funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
					FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV,
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
						read_rs = 1'b1;
						read_rt = 1'b1;
					end
					// shift amount comes from shamt
					FN_SLL, FN_SRL, FN_SRA: read_rt = 1'b1;
					FN_JR, FN_JALR, FN_MTHI, FN_MTLO: read_rs = 1'b1;
					default: ;
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
			OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_BLEZ, OP_BGTZ: read_rs = 1'b1;
			OP_BEQ, OP_BNE, OP_SW, OP_SB, OP_SH: begin
				read_rs = 1'b1;
				read_rt = 1'b1;
			end
			OP_REGIMM: read_rs = rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
			OP_COP0:   read_rt = (rs == RS_MTC0);
			default: ;
		endcase
	end

endmodule

//--- design/special_decoder.sv
`timescale 1ns/1ps

module special_decoder import mips_decode_pkg::*; (
	input  instr_t instr,
	output logic   hilo_read,
	output logic   hilo_write,
	output logic   mul_div_en,
	output logic   cp0_read,
	output logic   cp0_write,
	output logic   eret,
	output logic   syscall,
	output logic   brk
);

	opcode_t  op;
	funct_t   funct;
	reg_idx_t rs;
	logic     is_rtype;
	logic     is_cop0;

	assign op    = instr[OP_MSB:OP_LSB];
	assign funct = instr[FUNCT_MSB:FUNCT_LSB];
	assign rs    = instr[RS_MSB:RS_LSB];

	assign is_rtype = (op == OP_RTYPE);
	assign is_cop0  = (op == OP_COP0);

	// HI/LO and multiplier
	assign hilo_read  = is_rtype && (funct inside {FN_MFHI, FN_MFLO});
	assign hilo_write = is_rtype && (funct inside {FN_MTHI, FN_MTLO});
	assign mul_div_en = is_rtype && (funct inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});

	assign cp0_read  = is_cop0 && (rs == RS_MFC0);
	assign cp0_write = is_cop0 && (rs == RS_MTC0);
	// eret needs the full word, a near miss is reserved
	assign eret      = is_cop0 && (instr[RS_MSB:FUNCT_LSB] == ERET_WORD);

	assign syscall = is_rtype && (funct == FN_SYSCALL);
	assign brk     = is_rtype && (funct == FN_BREAK);

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_decode_pkg::*; (
	input  logic         clk,
	input  logic         arst_n,
	input  instr_t       instr,
	input  logic         instr_valid,
	input  logic         stall,
	input  logic         flush,
	output logic         ex_valid,
	output logic         reg_write,
	output logic         reg_dst,
	output logic         is_imm,
	output logic         sign_ext,
	output logic         mem_to_reg,
	output logic         mem_read,
	output logic         mem_write,
	output alu_op_t      alu_op,
	output branch_cond_t branch_cond,
	output logic         read_rs,
	output logic         read_rt,
	output logic         hilo_read,
	output logic         hilo_write,
	output logic         mul_div_en,
	output logic         cp0_read,
	output logic         cp0_write,
	output logic         is_mfc,
	output logic         eret,
	output logic         syscall,
	output logic         brk,
	output logic         reserved_instr,
	output logic         single_issue
);

	logic         reg_write_d, reg_dst_d, is_imm_d, sign_ext_d, mem_to_reg_d;
	logic         mem_read_d, mem_write_d, is_mfc_d, reserved_d, single_issue_d;
	logic         read_rs_d, read_rt_d;
	logic         hilo_read_d, hilo_write_d, mul_div_en_d;
	logic         cp0_read_d, cp0_write_d, eret_d, syscall_d, brk_d;
	alu_class_t   alu_class;
	alu_op_t      alu_op_d;
	branch_cond_t branch_cond_d;
	logic [12:0]  en_d;
	logic [12:0]  en_q;

	main_decoder i_main_decoder (
		.instr(instr), .reg_write(reg_write_d), .reg_dst(reg_dst_d), .is_imm(is_imm_d),
		.sign_ext(sign_ext_d), .mem_to_reg(mem_to_reg_d), .mem_read(mem_read_d),
		.mem_write(mem_write_d), .is_mfc(is_mfc_d), .alu_class(alu_class),
		.reserved_instr(reserved_d), .single_issue(single_issue_d)
	);

	alu_decoder i_alu_decoder (.alu_class(alu_class), .instr(instr), .alu_op(alu_op_d));

	branch_decoder i_branch_decoder (.instr(instr), .branch_cond(branch_cond_d));

	operand_decoder i_operand_decoder (.instr(instr), .read_rs(read_rs_d), .read_rt(read_rt_d));

	special_decoder i_special_decoder (
		.instr(instr), .hilo_read(hilo_read_d), .hilo_write(hilo_write_d),
		.mul_div_en(mul_div_en_d), .cp0_read(cp0_read_d), .cp0_write(cp0_write_d),
		.eret(eret_d), .syscall(syscall_d), .brk(brk_d)
	);

	// enables only count for a valid instruction
	assign en_d = {13{instr_valid}} & {reg_write_d, mem_read_d, mem_write_d,
		hilo_read_d, hilo_write_d, mul_div_en_d, cp0_read_d, cp0_write_d,
		eret_d, syscall_d, brk_d, reserved_d, single_issue_d};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			en_q     <= '0;
		end else if (flush) begin
			ex_valid <= 1'b0;
			en_q     <= '0;
		end else if (!stall) begin
			ex_valid <= instr_valid;
			en_q     <= en_d;
		end
	end

	// payload, qualified by ex_valid downstream
	always_ff @(posedge clk) begin
		if (!stall) begin
			reg_dst     <= reg_dst_d;
			is_imm      <= is_imm_d;
			sign_ext    <= sign_ext_d;
			mem_to_reg  <= mem_to_reg_d;
			is_mfc      <= is_mfc_d;
			alu_op      <= alu_op_d;
			branch_cond <= branch_cond_d;
			read_rs     <= read_rs_d;
			read_rt     <= read_rt_d;
		end
	end

	assign {reg_write, mem_read, mem_write, hilo_read, hilo_write, mul_div_en,
		cp0_read, cp0_write, eret, syscall, brk, reserved_instr, single_issue} = en_q;

endmodule

//--- tb/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import mips_decode_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20;
	localparam int RAND_PER_OP    = 4;

	localparam funct_t ALU_FNS [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
		FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
	localparam opcode_t IMM_OPS [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
		OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	localparam opcode_t MEM_OPS [8] = '{OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU,
		OP_SW, OP_SB, OP_SH};
	localparam opcode_t FLOW_OPS [6] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J, OP_JAL};
	localparam reg_idx_t REGIMM_SELS [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
	localparam funct_t SPECIAL_FNS [12] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI,
		FN_MFLO, FN_MTHI, FN_MTLO, FN_SYSCALL, FN_BREAK, FN_JR, FN_JALR};

	typedef struct packed {
		logic         reg_write;
		logic         reg_dst;
		logic         is_imm;
		logic         sign_ext;
		logic         mem_to_reg;
		logic         mem_read;
		logic         mem_write;
		alu_op_t      alu_op;
		branch_cond_t branch_cond;
		logic         read_rs;
		logic         read_rt;
		logic         hilo_read;
		logic         hilo_write;
		logic         mul_div_en;
		logic         cp0_read;
		logic         cp0_write;
		logic         is_mfc;
		logic         eret;
		logic         syscall;
		logic         brk;
		logic         reserved_instr;
		logic         single_issue;
	} ctrl_t;

	logic         clk;
	logic         arst_n;
	instr_t       instr;
	logic         instr_valid;
	logic         stall;
	logic         flush;
	logic         ex_valid;
	logic         reg_write;
	logic         reg_dst;
	logic         is_imm;
	logic         sign_ext;
	logic         mem_to_reg;
	logic         mem_read;
	logic         mem_write;
	alu_op_t      alu_op;
	branch_cond_t branch_cond;
	logic         read_rs;
	logic         read_rt;
	logic         hilo_read;
	logic         hilo_write;
	logic         mul_div_en;
	logic         cp0_read;
	logic         cp0_write;
	logic         is_mfc;
	logic         eret;
	logic         syscall;
	logic         brk;
	logic         reserved_instr;
	logic         single_issue;

	logic [31:0] rng;
	// expected outputs of the last accepted instruction
	ctrl_t       held;

	decode_stage i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected decode per instruction class
	function automatic ctrl_t ref_decode(input instr_t w);
		ctrl_t    c;
		opcode_t  op;
		funct_t   fn;
		reg_idx_t rs;
		reg_idx_t rt;
		op = w[31:26];
		fn = w[5:0];
		rs = w[25:21];
		rt = w[20:16];
		c = '0;
		c.sign_ext = 1'b1;
		case (op)
			OP_RTYPE: begin
				case (fn)
					FN_ADD:          c.alu_op = ALU_ADD;
					FN_ADDU:         c.alu_op = ALU_ADDU;
					FN_SUB:          c.alu_op = ALU_SUB;
					FN_SUBU:         c.alu_op = ALU_SUBU;
					FN_SLT:          c.alu_op = ALU_SLT;
					FN_SLTU:         c.alu_op = ALU_SLTU;
					FN_AND:          c.alu_op = ALU_AND;
					FN_OR:           c.alu_op = ALU_OR;
					FN_XOR:          c.alu_op = ALU_XOR;
					FN_NOR:          c.alu_op = ALU_NOR;
					FN_SLL, FN_SLLV: c.alu_op = ALU_SLL;
					FN_SRL, FN_SRLV: c.alu_op = ALU_SRL;
					FN_SRA, FN_SRAV: c.alu_op = ALU_SRA;
					default:         c.alu_op = ALU_NOP;
				endcase
				if (c.alu_op != ALU_NOP) begin
					c.reg_write = 1'b1;
					c.read_rt   = 1'b1;
					c.read_rs   = !(fn inside {FN_SLL, FN_SRL, FN_SRA});
				end else begin
					case (fn)
						FN_JR: c.read_rs = 1'b1;
						FN_JALR: begin
							c.reg_write = 1'b1;
							c.reg_dst   = 1'b1;
							c.read_rs   = 1'b1;
						end
						FN_MFHI, FN_MFLO: begin
							c.reg_write = 1'b1;
							c.hilo_read = 1'b1;
						end
						FN_MTHI, FN_MTLO: begin
							c.hilo_write = 1'b1;
							c.read_rs    = 1'b1;
						end
						FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
							c.mul_div_en = 1'b1;
							c.read_rs    = 1'b1;
							c.read_rt    = 1'b1;
						end
						FN_SYSCALL: c.syscall = 1'b1;
						FN_BREAK:   c.brk = 1'b1;
						default:    c.reserved_instr = 1'b1;
					endcase
				end
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				c.reg_write = 1'b1;
				c.is_imm    = 1'b1;
				c.read_rs   = (op != OP_LUI);
				case (op)
					OP_ADDI:  c.alu_op = ALU_ADD;
					OP_ADDIU: c.alu_op = ALU_ADDU;
					OP_SLTI:  c.alu_op = ALU_SLT;
					OP_SLTIU: c.alu_op = ALU_SLTU;
					OP_ANDI:  c.alu_op = ALU_AND;
					OP_ORI:   c.alu_op = ALU_OR;
					OP_XORI:  c.alu_op = ALU_XOR;
					default:  c.alu_op = ALU_LUI;
				endcase
				// only the arithmetic immediates sign-extend
				c.sign_ext = (c.alu_op inside {ALU_ADD, ALU_ADDU, ALU_SLT, ALU_SLTU});
			end
			OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_SW, OP_SB, OP_SH: begin
				c.is_imm       = 1'b1;
				c.alu_op       = ALU_ADDU;
				c.single_issue = 1'b1;
				c.read_rs      = 1'b1;
				if (op inside {OP_SW, OP_SB, OP_SH}) begin
					c.mem_write = 1'b1;
					c.read_rt   = 1'b1;
				end else begin
					c.reg_write  = 1'b1;
					c.mem_to_reg = 1'b1;
					c.mem_read   = 1'b1;
				end
			end
			OP_BEQ, OP_BNE: begin
				c.branch_cond = (op == OP_BEQ) ? BR_EQ : BR_NE;
				c.read_rs     = 1'b1;
				c.read_rt     = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: begin
				c.branch_cond = (op == OP_BLEZ) ? BR_LEZ : BR_GTZ;
				c.read_rs     = 1'b1;
			end
			OP_J: ;
			OP_JAL: begin
				c.reg_write = 1'b1;
				c.reg_dst   = 1'b1;
			end
			OP_REGIMM: begin
				if (rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL}) begin
					c.read_rs     = 1'b1;
					c.branch_cond = (rt inside {RT_BLTZ, RT_BLTZAL}) ? BR_LTZ : BR_GEZ;
					c.reg_write   = (rt inside {RT_BLTZAL, RT_BGEZAL});
					c.reg_dst     = (rt inside {RT_BLTZAL, RT_BGEZAL});
				end else begin
					c.reserved_instr = 1'b1;
				end
			end
			OP_COP0: begin
				c.single_issue = 1'b1;
				if (rs == RS_MFC0) begin
					c.reg_write = 1'b1;
					c.is_imm    = 1'b1;
					c.is_mfc    = 1'b1;
					c.cp0_read  = 1'b1;
				end else if (rs == RS_MTC0) begin
					c.cp0_write = 1'b1;
					c.read_rt   = 1'b1;
				end else if (w[25:0] == ERET_WORD) begin
					c.eret = 1'b1;
				end else begin
					c.reserved_instr = 1'b1;
				end
			end
			default: c.reserved_instr = 1'b1;
		endcase
		return c;
	endfunction

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("[ERROR] %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, act, exp);
			abort_run();
		end
	endtask

	// payload fields are only compared while valid
	task automatic check_outputs(input ctrl_t e, input logic valid);
		check_eq("ex_valid", 32'(ex_valid), 32'(valid));
		check_eq("reg_write", 32'(reg_write), 32'(valid & e.reg_write));
		check_eq("mem_read", 32'(mem_read), 32'(valid & e.mem_read));
		check_eq("mem_write", 32'(mem_write), 32'(valid & e.mem_write));
		check_eq("hilo_read", 32'(hilo_read), 32'(valid & e.hilo_read));
		check_eq("hilo_write", 32'(hilo_write), 32'(valid & e.hilo_write));
		check_eq("mul_div_en", 32'(mul_div_en), 32'(valid & e.mul_div_en));
		check_eq("cp0_read", 32'(cp0_read), 32'(valid & e.cp0_read));
		check_eq("cp0_write", 32'(cp0_write), 32'(valid & e.cp0_write));
		check_eq("eret", 32'(eret), 32'(valid & e.eret));
		check_eq("syscall", 32'(syscall), 32'(valid & e.syscall));
		check_eq("brk", 32'(brk), 32'(valid & e.brk));
		check_eq("reserved_instr", 32'(reserved_instr), 32'(valid & e.reserved_instr));
		check_eq("single_issue", 32'(single_issue), 32'(valid & e.single_issue));
		if (valid) begin
			check_eq("reg_dst", 32'(reg_dst), 32'(e.reg_dst));
			check_eq("is_imm", 32'(is_imm), 32'(e.is_imm));
			check_eq("sign_ext", 32'(sign_ext), 32'(e.sign_ext));
			check_eq("mem_to_reg", 32'(mem_to_reg), 32'(e.mem_to_reg));
			check_eq("is_mfc", 32'(is_mfc), 32'(e.is_mfc));
			check_eq("alu_op", 32'(alu_op), 32'(e.alu_op));
			check_eq("branch_cond", 32'(branch_cond), 32'(e.branch_cond));
			check_eq("read_rs", 32'(read_rs), 32'(e.read_rs));
			check_eq("read_rt", 32'(read_rt), 32'(e.read_rt));
		end
	endtask

	task automatic drive(input instr_t w, input logic v, input logic s, input logic f);
		instr       = w;
		instr_valid = v;
		stall       = s;
		flush       = f;
	endtask

	// at least one edge before ex_valid is looked at
	task automatic await_valid(input logic want);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (ex_valid !== want && cycles < TIMEOUT_CYCLES);
		if (ex_valid !== want) begin
			$display("timeout: ex_valid did not become %0b within %0d cycles", want, cycles);
			abort_run();
		end else begin
			check_eq("response cycles", 32'(cycles), 32'd1);
		end
	endtask

	task automatic run_instr(input instr_t w);
		drive(w, 1'b1, 1'b0, 1'b0);
		await_valid(1'b1);
		held = ref_decode(w);
		check_outputs(held, 1'b1);
	endtask

	task automatic reset_test();
		rng = lcg_next(rng);
		check_outputs('0, 1'b0);
		drive({OP_LW, rng[25:0]}, 1'b0, 1'b0, 1'b0);
		await_valid(1'b0);
		check_outputs('0, 1'b0);
		drive({OP_RTYPE, rng[25:6], FN_ADD}, 1'b0, 1'b0, 1'b0);
		await_valid(1'b0);
		check_outputs('0, 1'b0);
	endtask

	task automatic alu_test();
		for (int i = 0; i < 16; i++) begin
			repeat (RAND_PER_OP) begin
				rng = lcg_next(rng);
				run_instr({OP_RTYPE, rng[25:6], ALU_FNS[i]});
			end
		end
		for (int i = 0; i < 8; i++) begin
			repeat (RAND_PER_OP) begin
				rng = lcg_next(rng);
				run_instr({IMM_OPS[i], rng[25:0]});
			end
		end
	endtask

	task automatic mem_flow_test();
		for (int i = 0; i < 8; i++) begin
			repeat (RAND_PER_OP) begin
				rng = lcg_next(rng);
				run_instr({MEM_OPS[i], rng[25:0]});
			end
		end
		for (int i = 0; i < 6; i++) begin
			repeat (RAND_PER_OP) begin
				rng = lcg_next(rng);
				run_instr({FLOW_OPS[i], rng[25:0]});
			end
		end
		for (int i = 0; i < 4; i++) begin
			rng = lcg_next(rng);
			run_instr({OP_REGIMM, rng[25:21], REGIMM_SELS[i], rng[15:0]});
		end
	endtask

	task automatic special_test();
		for (int i = 0; i < 12; i++) begin
			rng = lcg_next(rng);
			run_instr({OP_RTYPE, rng[25:6], SPECIAL_FNS[i]});
		end
		rng = lcg_next(rng);
		run_instr({OP_COP0, RS_MTC0, rng[20:0]});
		run_instr({OP_COP0, RS_MFC0, rng[31:11]});
		run_instr({OP_COP0, ERET_WORD});
	endtask

	task automatic reserved_test();
		instr_t bad[$];
		rng = lcg_next(rng);
		// SPECIAL2, SPECIAL3, traps, MOVN, unaligned and LL, near ERET, unused opcode
		bad.push_back({6'b011100, rng[25:6], 6'b000010});
		bad.push_back({6'b011100, rng[25:6], 6'b100000});
		bad.push_back({6'b011111, rng[25:6], 6'b100000});
		bad.push_back({OP_RTYPE, rng[25:6], 6'b110100});
		bad.push_back({OP_REGIMM, rng[25:21], 5'b01000, rng[15:0]});
		bad.push_back({OP_RTYPE, rng[25:6], 6'b001011});
		bad.push_back({6'b100010, rng[25:0]});
		bad.push_back({6'b101110, rng[25:0]});
		bad.push_back({6'b110000, rng[25:0]});
		bad.push_back({OP_COP0, ERET_WORD ^ 26'h0000001});
		bad.push_back({OP_COP0, ERET_WORD ^ 26'h0010000});
		bad.push_back({6'b011000, rng[25:0]});
		foreach (bad[i]) begin
			run_instr(bad[i]);
			check_eq("reserved_instr", 32'(reserved_instr), 32'd1);
		end
	endtask

	task automatic stall_flush_test();
		instr_t w;
		rng = lcg_next(rng);
		run_instr({OP_LW, rng[25:0]});
		w = {OP_RTYPE, rng[25:6], FN_ADD};
		drive(w, 1'b1, 1'b1, 1'b0);
		repeat (3) begin
			await_valid(1'b1);
			check_outputs(held, 1'b1);
		end
		run_instr(w);
		drive({OP_SW, rng[25:0]}, 1'b1, 1'b0, 1'b1);
		await_valid(1'b0);
		check_outputs('0, 1'b0);
		run_instr({OP_ORI, rng[25:0]});
		// flush wins over stall
		drive({OP_RTYPE, rng[25:6], FN_MFHI}, 1'b1, 1'b1, 1'b1);
		await_valid(1'b0);
		check_outputs('0, 1'b0);
		drive(w, 1'b1, 1'b1, 1'b0);
		await_valid(1'b0);
		check_outputs('0, 1'b0);
		run_instr({OP_COP0, RS_MFC0, rng[20:0]});
	endtask

	initial begin
		#100000;
		$display("timeout: simulation ran past its time limit");
		abort_run();
	end

	initial begin
		rng         = 32'h4d8d7e35;
		held        = '0;
		arst_n      = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		stall       = 1'b0;
		flush       = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		reset_test();
		alu_test();
		mem_flow_test();
		special_test();
		reserved_test();
		stall_flush_test();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- decode_stage.f
design/mips_decode_pkg.sv
design/main_decoder.sv
design/alu_decoder.sv
design/branch_decoder.sv
design/operand_decoder.sv
design/special_decoder.sv
design/decode_stage.sv
tb/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_decode_stage -f decode_stage.f

./obj_dir/Vtb_decode_stage 2>&1 | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
